/* compile.f */
+incdir+source
source/cpu_pkg.sv
source/fetch_stage.sv
source/decode_stage.sv
source/execute_stage.sv
source/memory_arbiter.sv
source/writeback_stage.sv
source/cpu.sv
verif/cpu_assert.sv
verif/cpu_tb.sv

/* source/cpu.sv */
module cpu (
    input  logic              clk,
    input  logic              reset_n,
    output cpu_pkg::mem_req_t mem_req,
    input  cpu_pkg::word_t    mem_rdata,
    output cpu_pkg::word_t    output_port,
    output logic              output_valid,
    output cpu_pkg::word_t    num_inst,
    output logic              is_halted
);
    import cpu_pkg::*;

    if_id_t    if_id;
    id_ex_t    id_ex;
    ex_mem_t   ex_mem;
    mem_req_t  data_req;
    wb_write_t wb_write;
    word_t     fetch_addr;
    word_t     branch_target;
    logic      fetch_read;
    logic      fetch_ready;
    logic      stall;
    logic      flush;
    logic      branch_taken;
    logic      halt_seen;

    ////////////////////////////////////////////////////////////////////////////
    // Pipeline

    fetch_stage u_fetch (
        .clk           (clk),
        .reset_n       (reset_n),
        .stall         (stall),
        .flush         (flush),
        .halt_seen     (halt_seen),
        .branch_target (branch_target),
        .branch_taken  (branch_taken),
        .fetch_ready   (fetch_ready),
        .fetch_addr    (fetch_addr),
        .fetch_read    (fetch_read),
        .fetch_data    (mem_rdata),  // Instruction straight off the shared port
        .if_id         (if_id)
    );

    decode_stage u_decode (
        .clk           (clk),
        .reset_n       (reset_n),
        .if_id         (if_id),
        .ex_dest       (id_ex),
        .mem_dest      (ex_mem),
        .wb_write      (wb_write),
        .stall         (stall),
        .flush         (flush),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .halt_seen     (halt_seen),
        .id_ex         (id_ex)
    );

    execute_stage u_execute (
        .clk      (clk),
        .reset_n  (reset_n),
        .id_ex    (id_ex),
        .wb_write (wb_write),
        .mem_req  (data_req),
        .ex_mem   (ex_mem)
    );

    memory_arbiter u_arbiter (
        .data_req    (data_req),
        .fetch_read  (fetch_read),
        .fetch_addr  (fetch_addr),
        .mem_req     (mem_req),
        .fetch_ready (fetch_ready)
    );

    writeback_stage u_writeback (
        .clk          (clk),
        .reset_n      (reset_n),
        .ex_mem       (ex_mem),
        .mem_rdata    (mem_rdata),
        .wb_write     (wb_write),
        .output_port  (output_port),
        .output_valid (output_valid),
        .num_inst     (num_inst),
        .is_halted    (is_halted)
    );

endmodule

/* source/cpu_config.svh */
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// Data and address word
`define CPU_WORD_WIDTH 16

// Register file
`define CPU_REG_ADDR_WIDTH 2
`define CPU_REG_COUNT 4

// I-format immediate field
`define CPU_IMM_WIDTH 8

// First fetch address after reset
`define CPU_RESET_PC 0

`endif

/* source/cpu_pkg.sv */
`include "cpu_config.svh"

package cpu_pkg;

    typedef logic [`CPU_WORD_WIDTH-1:0]     word_t;
    typedef logic [`CPU_REG_ADDR_WIDTH-1:0] reg_idx_t;
    typedef logic [`CPU_IMM_WIDTH-1:0]      imm_t;

    typedef enum logic [3:0] {
        OP_BNE = 4'd0,
        OP_BEQ = 4'd1,
        OP_ADI = 4'd4,
        OP_LHI = 4'd6,
        OP_LWD = 4'd7,
        OP_SWD = 4'd8,
        OP_ALU = 4'd15
    } opcode_e;

    typedef enum logic [5:0] {
        F_ADD = 6'd0,
        F_SUB = 6'd1,
        F_AND = 6'd2,
        F_ORR = 6'd3,
        F_WWD = 6'd28,
        F_HLT = 6'd29
    } funct_e;

    typedef struct packed {
        opcode_e  opcode;
        reg_idx_t rs;
        reg_idx_t rt;
        reg_idx_t rd;
        funct_e   funct;
    } r_fmt_t;

    typedef struct packed {
        opcode_e  opcode;
        reg_idx_t rs;
        reg_idx_t rt;
        imm_t     imm;
    } i_fmt_t;

    // Same 16-bit word, two views
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } instr_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_PASS_B
    } alu_op_e;

    typedef struct packed {
        logic    reg_write;
        logic    dest_is_rd;  // Else rt
        logic    mem_read;
        logic    mem_write;
        logic    alu_src_imm;
        logic    wwd;
        logic    halt;
        alu_op_e alu_op;
    } ctrl_t;

    typedef struct packed {
        logic   valid;
        word_t  pc;
        instr_t instr;
    } if_id_t;

    typedef struct packed {
        logic     valid;
        ctrl_t    ctrl;
        reg_idx_t rs;
        reg_idx_t rt;
        reg_idx_t dest;
        word_t    rs_val;
        word_t    rt_val;
        imm_t     imm;
    } id_ex_t;

    typedef struct packed {
        logic     valid;
        ctrl_t    ctrl;
        reg_idx_t dest;
        word_t    alu_result;
        word_t    store_data;
    } ex_mem_t;

    typedef struct packed {
        logic     valid;
        ctrl_t    ctrl;
        reg_idx_t dest;
        word_t    alu_result;
        word_t    load_data;
    } mem_wb_t;

    typedef struct packed {
        logic  read;
        logic  write;
        word_t addr;
        word_t wdata;
    } mem_req_t;

    typedef struct packed {
        logic     en;
        reg_idx_t dest;
        word_t    data;
    } wb_write_t;

    function automatic word_t sign_ext(input imm_t imm);
        return {{(`CPU_WORD_WIDTH-`CPU_IMM_WIDTH){imm[`CPU_IMM_WIDTH-1]}}, imm};
    endfunction

endpackage

/* source/decode_stage.sv */
`include "cpu_config.svh"

module decode_stage (
    input  logic               clk,
    input  logic               reset_n,
    input  cpu_pkg::if_id_t    if_id,
    input  cpu_pkg::id_ex_t    ex_dest,
    input  cpu_pkg::ex_mem_t   mem_dest,
    input  cpu_pkg::wb_write_t wb_write,
    output logic               stall,
    output logic               flush,
    output logic               branch_taken,
    output cpu_pkg::word_t     branch_target,
    output logic               halt_seen,
    output cpu_pkg::id_ex_t    id_ex
);
    import cpu_pkg::*;

    word_t    regs [`CPU_REG_COUNT];
    instr_t   instr;
    ctrl_t    ctrl;
    reg_idx_t rs;
    reg_idx_t rt;
    reg_idx_t dest;
    word_t    rs_val;
    word_t    rt_val;
    logic     uses_rs;
    logic     uses_rt;
    logic     is_branch;
    logic     ex_hit;
    logic     mem_hit;
    logic     load_use;
    logic     halt_q;

    assign instr = if_id.instr;
    assign rs    = instr.r.rs;
    assign rt    = instr.r.rt;
    assign dest  = ctrl.dest_is_rd ? instr.r.rd : instr.r.rt;

    ////////////////////////////////////////////////////////////////////////////
    // Control decode

    always_comb begin
        ctrl      = '0;
        uses_rs   = 1'b0;
        uses_rt   = 1'b0;
        is_branch = 1'b0;
        case (instr.r.opcode)
            OP_ALU: begin
                case (instr.r.funct)
                    F_ADD, F_SUB, F_AND, F_ORR: begin
                        ctrl.reg_write  = 1'b1;
                        ctrl.dest_is_rd = 1'b1;
                        uses_rs         = 1'b1;
                        uses_rt         = 1'b1;
                        case (instr.r.funct)
                            F_SUB:   ctrl.alu_op = ALU_SUB;
                            F_AND:   ctrl.alu_op = ALU_AND;
                            F_ORR:   ctrl.alu_op = ALU_OR;
                            default: ctrl.alu_op = ALU_ADD;
                        endcase
                    end
                    F_WWD: begin
                        ctrl.wwd = 1'b1;
                        uses_rs  = 1'b1;
                    end
                    F_HLT:   ctrl.halt = 1'b1;
                    default: ;
                endcase
            end
            OP_ADI: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                uses_rs          = 1'b1;
            end
            OP_LHI: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.alu_op      = ALU_PASS_B;
            end
            OP_LWD: begin
                ctrl.reg_write   = 1'b1;
                ctrl.mem_read    = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                uses_rs          = 1'b1;
            end
            OP_SWD: begin
                ctrl.mem_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                uses_rs          = 1'b1;
                uses_rt          = 1'b1;
            end
            OP_BEQ, OP_BNE: begin
                is_branch = 1'b1;
                uses_rs   = 1'b1;
                uses_rt   = 1'b1;
            end
            default: ;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Register file, write-back value visible in the same cycle

    always_comb begin
        rs_val = regs[rs];
        rt_val = regs[rt];
        if (wb_write.en && wb_write.dest == rs) rs_val = wb_write.data;
        if (wb_write.en && wb_write.dest == rt) rt_val = wb_write.data;
    end

    always_ff @(posedge clk) begin
        if (reset_n) begin
            for (int i = 0; i < `CPU_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_write.en) begin
            regs[wb_write.dest] <= wb_write.data;
        end
    end

    // Hazards against EX and MEM
    assign ex_hit = ex_dest.valid && ex_dest.ctrl.reg_write &&
                    ((uses_rs && ex_dest.dest == rs) || (uses_rt && ex_dest.dest == rt));
    assign mem_hit = mem_dest.valid && mem_dest.ctrl.reg_write &&
                     ((uses_rs && mem_dest.dest == rs) || (uses_rt && mem_dest.dest == rt));
    assign load_use = ex_hit && ex_dest.ctrl.mem_read;

    // Branch waits until both sources sit in the register file
    assign stall = if_id.valid && (load_use || (is_branch && (ex_hit || mem_hit)));

    assign branch_target = if_id.pc + word_t'(1) + sign_ext(instr.i.imm);
    assign branch_taken  = if_id.valid && is_branch && !stall &&
                           ((instr.i.opcode == OP_BEQ) == (rs_val == rt_val));
    assign flush         = branch_taken;
    assign halt_seen     = halt_q || (if_id.valid && ctrl.halt);

    always_ff @(posedge clk) begin
        if (reset_n) begin
            id_ex.valid <= 1'b0;
            halt_q      <= 1'b0;
        end else begin
            id_ex.valid <= if_id.valid && !stall;  // Bubble while stalled
            if (if_id.valid && ctrl.halt && !stall) begin
                halt_q <= 1'b1;
            end
        end
        id_ex.ctrl   <= ctrl;
        id_ex.rs     <= rs;
        id_ex.rt     <= rt;
        id_ex.dest   <= dest;
        id_ex.rs_val <= rs_val;
        id_ex.rt_val <= rt_val;
        id_ex.imm    <= instr.i.imm;
    end

endmodule

/* source/execute_stage.sv */
`include "cpu_config.svh"

module execute_stage (
    input  logic               clk,
    input  logic               reset_n,
    input  cpu_pkg::id_ex_t    id_ex,
    input  cpu_pkg::wb_write_t wb_write,
    output cpu_pkg::mem_req_t  mem_req,
    output cpu_pkg::ex_mem_t   ex_mem
);
    import cpu_pkg::*;

    word_t opnd_a;
    word_t opnd_b;
    word_t imm_word;
    word_t alu_b;
    word_t alu_out;
    word_t result;

    // Youngest producer wins
    function automatic word_t forward(input reg_idx_t src, input word_t reg_val);
        if (ex_mem.valid && ex_mem.ctrl.reg_write && ex_mem.dest == src) begin
            return ex_mem.alu_result;
        end
        if (wb_write.en && wb_write.dest == src) begin
            return wb_write.data;
        end
        return reg_val;
    endfunction

    always_comb begin
        opnd_a = forward(id_ex.rs, id_ex.rs_val);
        opnd_b = forward(id_ex.rt, id_ex.rt_val);
    end

    ////////////////////////////////////////////////////////////////////////////
    // ALU

    // LHI is the only pass-B user
    assign imm_word = (id_ex.ctrl.alu_op == ALU_PASS_B) ?
                      {id_ex.imm, {(`CPU_WORD_WIDTH-`CPU_IMM_WIDTH){1'b0}}} :
                      sign_ext(id_ex.imm);
    assign alu_b = id_ex.ctrl.alu_src_imm ? imm_word : opnd_b;

    always_comb begin
        case (id_ex.ctrl.alu_op)
            ALU_SUB:    alu_out = opnd_a - alu_b;
            ALU_AND:    alu_out = opnd_a & alu_b;
            ALU_OR:     alu_out = opnd_a | alu_b;
            ALU_PASS_B: alu_out = alu_b;
            default:    alu_out = opnd_a + alu_b;
        endcase
    end

    assign result = id_ex.ctrl.wwd ? opnd_a : alu_out;  // WWD carries rs

    always_ff @(posedge clk) begin
        if (reset_n) begin
            ex_mem.valid <= 1'b0;
        end else begin
            ex_mem.valid <= id_ex.valid;
        end
        ex_mem.ctrl       <= id_ex.ctrl;
        ex_mem.dest       <= id_ex.dest;
        ex_mem.alu_result <= result;
        ex_mem.store_data <= opnd_b;
    end

    // Data access of the entry in MEM
    assign mem_req = '{
        read:  ex_mem.valid && ex_mem.ctrl.mem_read,
        write: ex_mem.valid && ex_mem.ctrl.mem_write,
        addr:  ex_mem.alu_result,
        wdata: ex_mem.store_data
    };

endmodule

/* source/fetch_stage.sv */
`include "cpu_config.svh"

module fetch_stage (
    input  logic            clk,
    input  logic            reset_n,
    input  logic            stall,
    input  logic            flush,
    input  logic            halt_seen,
    input  cpu_pkg::word_t  branch_target,
    input  logic            branch_taken,
    input  logic            fetch_ready,
    output cpu_pkg::word_t  fetch_addr,
    output logic            fetch_read,
    input  cpu_pkg::word_t  fetch_data,
    output cpu_pkg::if_id_t if_id
);
    import cpu_pkg::*;

    word_t pc;
    logic  accept;

    assign fetch_addr = pc;
    assign fetch_read = !halt_seen && !stall;
    assign accept     = fetch_read && fetch_ready;  // Port granted this cycle

    always_ff @(posedge clk) begin
        if (reset_n) begin
            pc          <= word_t'(`CPU_RESET_PC);
            if_id.valid <= 1'b0;
        end else if (!stall) begin
            if (branch_taken) begin
                pc <= branch_target;
            end else if (accept) begin
                pc <= pc + word_t'(1);
            end
            // Wrong-path word or lost arbitration leaves a bubble
            if_id.valid <= accept && !flush;
        end
        if (!stall) begin
            if_id.pc    <= pc;
            if_id.instr <= fetch_data;
        end
    end

endmodule

/* source/memory_arbiter.sv */
module memory_arbiter (
    input  cpu_pkg::mem_req_t data_req,
    input  logic              fetch_read,
    input  cpu_pkg::word_t    fetch_addr,
    output cpu_pkg::mem_req_t mem_req,
    output logic              fetch_ready
);
    import cpu_pkg::*;

    mem_req_t fetch_req;
    logic     data_busy;

    assign fetch_req = '{
        read:  fetch_read,
        write: 1'b0,
        addr:  fetch_addr,
        wdata: '0
    };

    // Data side always wins
    assign data_busy   = data_req.read || data_req.write;
    assign mem_req     = data_busy ? data_req : fetch_req;
    assign fetch_ready = fetch_read && !data_busy;

endmodule

/* source/writeback_stage.sv */
module writeback_stage (
    input  logic               clk,
    input  logic               reset_n,
    input  cpu_pkg::ex_mem_t   ex_mem,
    input  cpu_pkg::word_t     mem_rdata,
    output cpu_pkg::wb_write_t wb_write,
    output cpu_pkg::word_t     output_port,
    output logic               output_valid,
    output cpu_pkg::word_t     num_inst,
    output logic               is_halted
);
    import cpu_pkg::*;

    mem_wb_t mem_wb;
    word_t   wb_data;

    always_ff @(posedge clk) begin
        if (reset_n) begin
            mem_wb.valid <= 1'b0;
        end else begin
            mem_wb.valid <= ex_mem.valid;
        end
        mem_wb.ctrl       <= ex_mem.ctrl;
        mem_wb.dest       <= ex_mem.dest;
        mem_wb.alu_result <= ex_mem.alu_result;
        if (ex_mem.ctrl.mem_read) begin
            mem_wb.load_data <= mem_rdata;  // Memory answers in the MEM cycle
        end
    end

    assign wb_data  = mem_wb.ctrl.mem_read ? mem_wb.load_data : mem_wb.alu_result;
    assign wb_write = '{
        en:   mem_wb.valid && mem_wb.ctrl.reg_write,
        dest: mem_wb.dest,
        data: wb_data
    };

    ////////////////////////////////////////////////////////////////////////////
    // Retirement

    assign output_valid = mem_wb.valid && mem_wb.ctrl.wwd;
    assign output_port  = mem_wb.alu_result;

    always_ff @(posedge clk) begin
        if (reset_n) begin
            num_inst  <= '0;
            is_halted <= 1'b0;
        end else if (mem_wb.valid) begin
            num_inst <= num_inst + word_t'(1);
            if (mem_wb.ctrl.halt) begin
                is_halted <= 1'b1;  // Sticky until reset
            end
        end
    end

endmodule

/* verif/cpu_assert.sv */
module cpu_assert (
    input logic              clk,
    input logic              reset_n,
    input cpu_pkg::mem_req_t mem_req,
    input logic              output_valid,
    input logic              is_halted
);

    int failures = 0;  // Polled by the testbench

    ////////////////////////////////////////////////////////////////////////////
    // Shared memory port

    port_exclusive: assert property (
        @(posedge clk) disable iff (reset_n)
        !(mem_req.read && mem_req.write)
    ) else begin
        failures++;
        $error("memory port has read and write set in the same cycle");
    end

    ////////////////////////////////////////////////////////////////////////////
    // Halt behavior

    quiet_after_halt: assert property (
        @(posedge clk) disable iff (reset_n)
        is_halted |-> !output_valid
    ) else begin
        failures++;
        $error("output_valid pulsed while the CPU is halted");
    end

    halt_sticky: assert property (
        @(posedge clk) disable iff (reset_n)
        is_halted |=> is_halted
    ) else begin
        failures++;
        $error("is_halted fell without a reset");
    end

endmodule

/* verif/cpu_tb.sv */
module cpu_tb;
    import cpu_pkg::*;

    localparam int    MEM_ADDR_BITS = 8;
    localparam int    MEM_WORDS     = 1 << MEM_ADDR_BITS;
    localparam string TRACE_FILE    = "verif/cpu_trace.txt";

    logic     clk;
    logic     reset_n;
    mem_req_t mem_req;
    word_t    mem_rdata;
    word_t    output_port;
    logic     output_valid;
    word_t    num_inst;
    logic     is_halted;

    word_t mem [MEM_WORDS];
    word_t exp_outputs [$];
    word_t check_addrs [$];
    word_t check_words [$];
    word_t exp_count;
    int    image_words  = 0;
    int    cycle_limit  = 0;
    int    cycles       = 0;
    int    outputs_seen = 0;

    cpu u_cpu (
        .clk          (clk),
        .reset_n      (reset_n),
        .mem_req      (mem_req),
        .mem_rdata    (mem_rdata),
        .output_port  (output_port),
        .output_valid (output_valid),
        .num_inst     (num_inst),
        .is_halted    (is_halted)
    );

    bind cpu cpu_assert u_cpu_assert (
        .clk          (clk),
        .reset_n      (reset_n),
        .mem_req      (mem_req),
        .output_valid (output_valid),
        .is_halted    (is_halted)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Memory model, combinational read and write at the edge

    assign mem_rdata = mem[mem_req.addr[MEM_ADDR_BITS-1:0]];

    always @(posedge clk) begin
        if (!reset_n && mem_req.write) begin
            mem[mem_req.addr[MEM_ADDR_BITS-1:0]] <= mem_req.wdata;
        end
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check_output(input word_t got, input word_t exp);
        if (got !== exp) begin
            fail_run($sformatf("[FAIL] %0t output %0d is %h, expected %h",
                               $time, outputs_seen, got, exp));
        end
    endtask

    task automatic check_mem(input word_t addr, input word_t got, input word_t exp);
        if (got !== exp) begin
            fail_run($sformatf("[FAIL] %0t memory word %h is %h, expected %h",
                               $time, addr, got, exp));
        end
    endtask

    task automatic check_count(input word_t got, input word_t exp);
        if (got !== exp) begin
            fail_run($sformatf("[FAIL] %0t num_inst is %0d, expected %0d",
                               $time, got, exp));
        end
    endtask

    task automatic load_trace();
        int     fd;
        int     n;
        byte    kind;
        word_t  f1;
        word_t  f2;
        string  line;
        instr_t instr;
        logic   has_halt;
        logic   has_count;

        has_halt  = 1'b0;
        has_count = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = '0;
        end
        fd = $fopen(TRACE_FILE, "r");
        if (fd == 0) begin
            fail_run({"Cannot open the trace file ", TRACE_FILE});
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (line.len() < 3 || line[0] == "#") begin
                continue;  // Blank or comment
            end
            n = $sscanf(line, "%c %h %h", kind, f1, f2);
            if (n != 3) begin
                fail_run({"Malformed trace line: ", line});
            end
            case (kind)
                "M": begin
                    mem[f1[MEM_ADDR_BITS-1:0]] = f2;
                    image_words++;
                    instr = f2;
                    if (instr.r.opcode == OP_ALU && instr.r.funct == F_HLT) begin
                        has_halt = 1'b1;
                    end
                end
                "O": exp_outputs.push_back(f2);
                "E": begin
                    check_addrs.push_back(f1);
                    check_words.push_back(f2);
                end
                "C": begin
                    exp_count = f2;
                    has_count = 1'b1;
                end
                default: fail_run({"Unknown line kind in trace: ", line});
            endcase
        end
        $fclose(fd);
        if (!has_halt || !has_count) begin
            fail_run("Trace lacks a HLT in its program or an expected count");
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Per-cycle monitor

    always @(negedge clk) begin
        if (!reset_n) begin
            cycles++;
            if (cycles > cycle_limit) begin
                fail_run($sformatf("Timeout, no halt within %0d cycles", cycle_limit));
            end
            if (u_cpu.u_cpu_assert.failures != 0) begin
                fail_run("A concurrent assertion on the CPU failed");
            end
            if ((mem_req.read || mem_req.write) && mem_req.addr >= word_t'(MEM_WORDS)) begin
                fail_run($sformatf("Memory access outside the model at %h", mem_req.addr));
            end
            if (output_valid) begin
                if (exp_outputs.size() == 0) begin
                    fail_run($sformatf("Output %h appeared beyond the trace", output_port));
                end
                check_output(output_port, exp_outputs.pop_front());
                outputs_seen++;
            end
        end
    end

    initial begin
        reset_n = 1'b1;
        load_trace();
        cycle_limit = 8 * image_words + 50;
        repeat (4) @(posedge clk);
        reset_n <= 1'b0;
        while (is_halted !== 1'b1) begin
            @(negedge clk);
        end
        repeat (8) @(negedge clk);  // Pipeline must stay quiet after halt
        if (exp_outputs.size() != 0) begin
            fail_run($sformatf("Halted with %0d expected outputs missing", exp_outputs.size()));
        end
        foreach (check_addrs[i]) begin
            check_mem(check_addrs[i], mem[check_addrs[i][MEM_ADDR_BITS-1:0]], check_words[i]);
        end
        check_count(num_inst, exp_count);
        $display("No errors");
        $finish;
    end

endmodule

/* verif/cpu_trace.txt */
# Columns: kind, address or output index, word (hex); text after the word is ignored
# M memory image, O expected output in order, E expected final memory, C retired count
M 0000 6112 LHI r1, 0x12
M 0001 4534 ADI r1, r1, 0x34
M 0002 F41C WWD r1
M 0003 4205 ADI r2, r0, 0x05
M 0004 F6C0 ADD r3, r1, r2
M 0005 FC1C WWD r3
M 0006 FEC1 SUB r3, r3, r2
M 0007 4FFE ADI r3, r3, -2
M 0008 FC1C WWD r3
M 0009 4270 ADI r2, r0, 0x70
M 000A FEC2 AND r3, r3, r2
M 000B 61A5 LHI r1, 0xA5
M 000C FDC3 ORR r3, r3, r1
M 000D FC1C WWD r3
M 000E 8360 SWD r3, 0x60(r0)
M 000F 7160 LWD r1, 0x60(r0)
M 0010 F580 ADD r2, r1, r1 load-use
M 0011 F81C WWD r2
M 0012 7361 LWD r3, 0x61(r0)
M 0013 FEC0 ADD r3, r3, r2 load-use
M 0014 FC1C WWD r3
M 0015 8362 SWD r3, 0x62(r0)
M 0016 1501 BEQ r1, r1, +1 taken
M 0017 F41C WWD r1 skipped
M 0018 0602 BNE r1, r2, +2 taken
M 0019 F81C WWD r2 skipped
M 001A F41C WWD r1 skipped
M 001B 1601 BEQ r1, r2, +1 not taken
M 001C F41C WWD r1
M 001D 0501 BNE r1, r1, +1 not taken
M 001E F81C WWD r2
M 001F 4207 ADI r2, r0, 7
M 0020 4307 ADI r3, r0, 7
M 0021 1E01 BEQ r3, r2, +1 on fresh ALU result
M 0022 F01C WWD r0 skipped
M 0023 7163 LWD r1, 0x63(r0)
M 0024 1601 BEQ r1, r2, +1 on fresh load
M 0025 F41C WWD r1 skipped
M 0026 F41C WWD r1
M 0027 F01D HLT
M 0028 FC1C WWD r3 never fetched
M 0061 0100 data
M 0063 0007 data
O 0000 1234
O 0001 1239
O 0002 1232
O 0003 A530
O 0004 4A60
O 0005 4B60
O 0006 A530
O 0007 4A60
O 0008 0007
E 0060 A530
E 0061 0100
E 0062 4B60
E 0063 0007
C 0000 0023 35 retired
